// File: rtl/bfly_pkg.sv
// shared types for the fixed-point radix-2 butterfly pipeline
// modules import it in their bodies and use scoped names on ports
package bfly_pkg;

    // one real or imaginary component
    localparam int SAMPLE_W = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    // pre-add and butterfly sums carry one guard bit
    typedef logic signed [SAMPLE_W:0]   sum_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // fft or ifft operating mode
    typedef enum logic {
        MODE_IFFT = 1'b0,
        MODE_FFT  = 1'b1
    } bfly_mode_e;

    // top input bundle, 97 bits
    typedef struct packed {
        bfly_mode_e mode;
        cplx_t      a;
        cplx_t      b;
        cplx_t      w;
    } bfly_in_t;

    // pre-add stage to multiplier stage
    typedef struct packed {
        logic       valid;
        bfly_mode_e mode;
        cplx_t      a;
        sample_t    b_re;
        sample_t    b_im;
        sample_t    w_re;
        // b_re + b_im, shared by both outputs
        sum_t       sum_k;
        // w_re + w_im
        sum_t       sum_re;
        // w_im - w_re
        sum_t       sum_im;
    } preadd_t;

    // multiplier stage to combine stage
    typedef struct packed {
        logic       valid;
        bfly_mode_e mode;
        cplx_t      a;
        cplx_t      y;
    } prod_t;

endpackage

// File: rtl/bfly_credit_ctrl.sv
// credit counter for the butterfly input side
// one credit per free sink slot, returned by the sink after it drains a result
`timescale 1ns/1ps

module bfly_credit_ctrl #(
    parameter int unsigned CREDIT_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_vld_i,
    input  logic credit_i,
    output logic in_rdy_o,
    output logic accept_o
);

    localparam int unsigned      CNT_W    = $clog2(CREDIT_DEPTH + 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CREDIT_DEPTH);

    // free slots in the sink buffer
    logic [CNT_W-1:0] credit_cnt;

    // ready straight from the counter, no dependence on in_vld_i
    assign in_rdy_o = (credit_cnt != '0);
    assign accept_o = in_vld_i & in_rdy_o;

    ////////////////////////////////////////////////////////////
    // credit bookkeeping
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CNT_FULL;
        end else begin
            case ({accept_o, credit_i})
                // take one slot
                2'b10: credit_cnt <= credit_cnt - CNT_W'(1);
                // sink freed one slot
                2'b01: credit_cnt <= credit_cnt + CNT_W'(1);
                // take and return cancel out
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // a full counter means nothing is in flight, so the sink has no credit to give back
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (credit_cnt <= CNT_FULL) && !(credit_i && (credit_cnt == CNT_FULL)))
        else $error("[FAIL] credit_cnt=%0h credit_i=%0h exceeds depth %0d",
                    credit_cnt, credit_i, CREDIT_DEPTH);

endmodule

// File: rtl/bfly_preadd.sv
// first pipeline stage of the butterfly
// registers the accepted operands, conjugates the twiddle for ifft and forms the pre-add sums
`timescale 1ns/1ps

module bfly_preadd (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               accept_i,
    input  bfly_pkg::bfly_in_t in_i,
    output bfly_pkg::preadd_t  pre_o
);

    import bfly_pkg::*;

    logic     in_vld_q;
    bfly_in_t in_q;
    // twiddle imaginary part after optional conjugation
    sample_t  w_im_c;

    ////////////////////////////////////////////////////////////
    // edge 0 input register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_vld_q <= 1'b0;
        end else begin
            in_vld_q <= accept_i;
        end
    end

    // operands only load on an accepted transfer
    always_ff @(posedge clk) begin
        if (accept_i) begin
            in_q <= in_i;
        end
    end

    // ifft runs with conj(w)
    // negating -32768 wraps back to -32768
    always_comb begin
        if (in_q.mode == MODE_IFFT) begin
            w_im_c = sample_t'(-in_q.w.im);
        end else begin
            w_im_c = in_q.w.im;
        end
    end

    ////////////////////////////////////////////////////////////
    // edge 1 pre-add sums
    ////////////////////////////////////////////////////////////
    // the k path needs b_re + b_im and the two corrections need w_re + w_im and w_im - w_re
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_o <= '0;
        end else begin
            pre_o.valid  <= in_vld_q;
            pre_o.mode   <= in_q.mode;
            pre_o.a      <= in_q.a;
            // single operands that the multipliers still need
            pre_o.b_re   <= in_q.b.re;
            pre_o.b_im   <= in_q.b.im;
            pre_o.w_re   <= in_q.w.re;
            // 17 bits keep every sum from overflowing
            pre_o.sum_k  <= sum_t'(in_q.b.re) + sum_t'(in_q.b.im);
            pre_o.sum_re <= sum_t'(in_q.w.re) + sum_t'(w_im_c);
            pre_o.sum_im <= sum_t'(w_im_c) - sum_t'(in_q.w.re);
        end
    end

endmodule

// File: rtl/bfly_cmul3.sv
// complex multiply y = b * w with three multipliers
// the shared product is k = w_re*(b_re+b_im)
// y_re = k - b_im*(w_re+w_im) and y_im = k + b_re*(w_im-w_re)
`timescale 1ns/1ps

module bfly_cmul3 #(
    parameter int unsigned FRAC_W = 14
) (
    input  logic              clk,
    input  logic              rst_n,
    input  bfly_pkg::preadd_t pre_i,
    output bfly_pkg::prod_t   prod_o
);

    import bfly_pkg::*;

    // 16 x 17 signed product
    localparam int unsigned PROD_W = 2 * SAMPLE_W + 1;
    // one more bit for the recombination
    localparam int unsigned YFUL_W = PROD_W + 1;

    logic                     mul_vld_q;
    bfly_mode_e               mul_mode_q;
    cplx_t                    mul_a_q;
    logic signed [PROD_W-1:0] k_q;
    logic signed [PROD_W-1:0] c_re_q;
    logic signed [PROD_W-1:0] c_im_q;
    logic signed [YFUL_W-1:0] y_re_full;
    logic signed [YFUL_W-1:0] y_im_full;

    ////////////////////////////////////////////////////////////
    // edge 2 raw products
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_vld_q <= 1'b0;
        end else begin
            mul_vld_q <= pre_i.valid;
        end
    end

    // one multiplier each with operands sign extended to full product width
    always_ff @(posedge clk) begin
        mul_mode_q <= pre_i.mode;
        mul_a_q    <= pre_i.a;
        k_q        <= PROD_W'(pre_i.w_re) * PROD_W'(pre_i.sum_k);
        c_re_q     <= PROD_W'(pre_i.b_im) * PROD_W'(pre_i.sum_re);
        c_im_q     <= PROD_W'(pre_i.b_re) * PROD_W'(pre_i.sum_im);
    end

    // full precision recombination is exact for any 16-bit operands
    assign y_re_full = YFUL_W'(k_q) - YFUL_W'(c_re_q);
    assign y_im_full = YFUL_W'(k_q) + YFUL_W'(c_im_q);

    ////////////////////////////////////////////////////////////
    // edge 3 scaled product
    ////////////////////////////////////////////////////////////
    // drop the twiddle fraction and then keep the low 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_o <= '0;
        end else begin
            prod_o.valid <= mul_vld_q;
            prod_o.mode  <= mul_mode_q;
            prod_o.a     <= mul_a_q;
            prod_o.y.re  <= sample_t'(y_re_full >>> FRAC_W);
            prod_o.y.im  <= sample_t'(y_im_full >>> FRAC_W);
        end
    end

    // valid chain from pre-add through this stage stays known once out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({pre_i.valid, mul_vld_q, prod_o.valid}))
        else $error("[FAIL] pre_i.valid=%0h mul_vld_q=%0h prod_o.valid=%0h has X",
                    pre_i.valid, mul_vld_q, prod_o.valid);

endmodule

// File: rtl/bfly_combine.sv
// last butterfly stage that registers ao = a + y and bo = a - y
// fft wraps to 16 bits and ifft halves the 17-bit result
`timescale 1ns/1ps

module bfly_combine (
    input  logic            clk,
    input  logic            rst_n,
    input  bfly_pkg::prod_t prod_i,
    output bfly_pkg::cplx_t ao_o,
    output bfly_pkg::cplx_t bo_o,
    output logic            out_vld_o
);

    import bfly_pkg::*;

    sum_t add_re;
    sum_t add_im;
    sum_t sub_re;
    sum_t sub_im;

    // fft keeps bits 15:0 and ifft keeps bits 16:1
    function automatic sample_t fold_out(input sum_t x, input bfly_mode_e mode);
        if (mode == MODE_IFFT) begin
            return x[SAMPLE_W:1];
        end
        return x[SAMPLE_W-1:0];
    endfunction

    // guard bit sums
    always_comb begin
        add_re = sum_t'(prod_i.a.re) + sum_t'(prod_i.y.re);
        add_im = sum_t'(prod_i.a.im) + sum_t'(prod_i.y.im);
        sub_re = sum_t'(prod_i.a.re) - sum_t'(prod_i.y.re);
        sub_im = sum_t'(prod_i.a.im) - sum_t'(prod_i.y.im);
    end

    ////////////////////////////////////////////////////////////
    // edge 4 output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld_o <= 1'b0;
        end else begin
            out_vld_o <= prod_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        ao_o.re <= fold_out(add_re, prod_i.mode);
        ao_o.im <= fold_out(add_im, prod_i.mode);
        bo_o.re <= fold_out(sub_re, prod_i.mode);
        bo_o.im <= fold_out(sub_im, prod_i.mode);
    end

endmodule

// File: rtl/butterfly_top.sv
// radix-2 fft/ifft butterfly, credit flow control on the input
// five register stages from accept to out_vld_o, one result per cycle
`timescale 1ns/1ps

module butterfly_top #(
    // twiddle fraction bits
    parameter int unsigned FRAC_W       = 14,
    // sink buffer slots
    parameter int unsigned CREDIT_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    // source side
    input  bfly_pkg::bfly_in_t in_i,
    input  logic               in_vld_i,
    output logic               in_rdy_o,
    // sink side, one credit pulse per drained result
    input  logic               credit_i,
    output bfly_pkg::cplx_t    ao_o,
    output bfly_pkg::cplx_t    bo_o,
    output logic               out_vld_o
);

    import bfly_pkg::*;

    logic    accept;
    preadd_t pre;
    prod_t   prod;

    ////////////////////////////////////////////////////////////
    // flow control
    ////////////////////////////////////////////////////////////
    bfly_credit_ctrl #(
        .CREDIT_DEPTH (CREDIT_DEPTH)
    ) u_credit (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld_i (in_vld_i),
        .credit_i (credit_i),
        .in_rdy_o (in_rdy_o),
        .accept_o (accept)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////
    // edges 0 and 1
    bfly_preadd u_preadd (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept_i (accept),
        .in_i     (in_i),
        .pre_o    (pre)
    );

    // edges 2 and 3
    bfly_cmul3 #(
        .FRAC_W (FRAC_W)
    ) u_cmul3 (
        .clk    (clk),
        .rst_n  (rst_n),
        .pre_i  (pre),
        .prod_o (prod)
    );

    // edge 4
    bfly_combine u_combine (
        .clk       (clk),
        .rst_n     (rst_n),
        .prod_i    (prod),
        .ao_o      (ao_o),
        .bo_o      (bo_o),
        .out_vld_o (out_vld_o)
    );

endmodule

// File: include/tb_bfly_model.svh
// stimulus lfsr and bit-accurate butterfly reference for the testbench
// included inside the testbench module
`ifndef TB_BFLY_MODEL_SVH
`define TB_BFLY_MODEL_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// draw n bits (up to 32), one lfsr step per bit
function automatic logic [31:0] lfsr_bits(inout logic [15:0] s, input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
        s = lfsr_next(s);
        r = {r[30:0], s[0]};
    end
    return r;
endfunction

// fft wraps, ifft drops bit 0 of the 17-bit sum
function automatic bfly_pkg::sample_t ref_fold(input logic signed [16:0] x,
                                               input bfly_pkg::bfly_mode_e mode);
    if (mode == bfly_pkg::MODE_IFFT) begin
        return x[16:1];
    end
    return x[15:0];
endfunction

// direct four-product form, scaled after the add like the hardware
function automatic void bfly_ref(input  bfly_pkg::bfly_in_t x,
                                 input  int unsigned        frac_w,
                                 output bfly_pkg::cplx_t    ao,
                                 output bfly_pkg::cplx_t    bo);
    bfly_pkg::sample_t  w_im;
    logic signed [33:0] yr_full;
    logic signed [33:0] yi_full;
    bfly_pkg::cplx_t    y;
    // conjugate twiddle for ifft, wrapping at 16 bits
    w_im = (x.mode == bfly_pkg::MODE_IFFT) ? bfly_pkg::sample_t'(-x.w.im) : x.w.im;
    yr_full = 34'(x.b.re) * 34'(x.w.re) - 34'(x.b.im) * 34'(w_im);
    yi_full = 34'(x.b.re) * 34'(w_im) + 34'(x.b.im) * 34'(x.w.re);
    y.re = bfly_pkg::sample_t'(yr_full >>> frac_w);
    y.im = bfly_pkg::sample_t'(yi_full >>> frac_w);
    ao.re = ref_fold(17'(x.a.re) + 17'(y.re), x.mode);
    ao.im = ref_fold(17'(x.a.im) + 17'(y.im), x.mode);
    bo.re = ref_fold(17'(x.a.re) - 17'(y.re), x.mode);
    bo.im = ref_fold(17'(x.a.im) - 17'(y.im), x.mode);
endfunction

`endif

// File: testbench/tb_butterfly.sv
// testbench for butterfly_top with random fft and ifft operands against a bit-accurate model
// a credit-returning sink drains results and concurrent assertions compare each output
`timescale 1ns/1ps

module tb_butterfly;

    import bfly_pkg::*;

    `include "tb_bfly_model.svh"

    localparam int unsigned FRAC_W       = 14;
    localparam int unsigned CREDIT_DEPTH = 4;
    // cycles any single wait may take
    localparam int          TIMEOUT      = 200;

    logic     clk;
    logic     rst_n;
    bfly_in_t in_i;
    logic     in_vld_i;
    logic     in_rdy_o;
    logic     credit_i;
    cplx_t    ao_o;
    cplx_t    bo_o;
    logic     out_vld_o;

    // edge counter that stamps each accept cycle
    logic [31:0] cyc;
    // stimulus and sink draw from separate lfsr states
    logic [15:0] lfsr_s;
    logic [15:0] sink_lfsr;
    // sink holds back credits while set
    logic        withhold;
    // results taken by the sink and not yet credited
    int          held;
    // expected credit count tracked from the pins
    int          credits_exp;

    // scoreboard in acceptance order
    cplx_t       exp_ao_q[$];
    cplx_t       exp_bo_q[$];
    logic [31:0] exp_cyc_q[$];
    cplx_t       head_ao;
    cplx_t       head_bo;
    logic [31:0] head_cyc;
    int          sb_cnt;

    butterfly_top #(
        .FRAC_W       (FRAC_W),
        .CREDIT_DEPTH (CREDIT_DEPTH)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_i      (in_i),
        .in_vld_i  (in_vld_i),
        .in_rdy_o  (in_rdy_o),
        .credit_i  (credit_i),
        .ao_o      (ao_o),
        .bo_o      (bo_o),
        .out_vld_o (out_vld_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 32'd0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard and credit model
    ////////////////////////////////////////////////////////////
    // pop on each result and push the model result on each transfer
    always @(posedge clk) begin : scoreboard
        cplx_t ao;
        cplx_t bo;
        if (rst_n && out_vld_o && exp_ao_q.size() != 0) begin
            void'(exp_ao_q.pop_front());
            void'(exp_bo_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
        if (rst_n && in_vld_i && in_rdy_o) begin
            bfly_ref(in_i, FRAC_W, ao, bo);
            exp_ao_q.push_back(ao);
            exp_bo_q.push_back(bo);
            exp_cyc_q.push_back(cyc);
        end
        // head of queue as seen by the next edge
        if (exp_ao_q.size() != 0) begin
            head_ao  <= exp_ao_q[0];
            head_bo  <= exp_bo_q[0];
            head_cyc <= exp_cyc_q[0];
        end
        sb_cnt <= exp_ao_q.size();
    end

    // full after reset, one down per transfer, one up per credit pulse
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_exp <= int'(CREDIT_DEPTH);
        end else begin
            credits_exp <= credits_exp - int'(in_vld_i && in_rdy_o) + int'(credit_i);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_vld_o)
        else fail_now($sformatf("[FAIL] out_vld_o=%h during reset", $sampled(out_vld_o)));

    // ready follows the credit model through idle start, back-pressure and release
    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        in_rdy_o == (credits_exp != 0))
        else fail_now($sformatf("[FAIL] in_rdy_o=%h credits expected=%h",
                                $sampled(in_rdy_o), $sampled(credits_exp)));

    a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld_o |-> sb_cnt != 0)
        else fail_now("a result appeared with no transfer pending");

    a_ao: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld_o |-> ao_o == head_ao)
        else fail_now($sformatf("[FAIL] ao_o=%h expected=%h",
                                $sampled(ao_o), $sampled(head_ao)));

    a_bo: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld_o |-> bo_o == head_bo)
        else fail_now($sformatf("[FAIL] bo_o=%h expected=%h",
                                $sampled(bo_o), $sampled(head_bo)));

    // five edges from accept to the first edge that sees out_vld_o
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld_o |-> cyc == head_cyc + 32'd5)
        else fail_now($sformatf("[FAIL] out_vld_o at cyc=%h expected cyc=%h",
                                $sampled(cyc), $sampled(head_cyc) + 32'd5));

    a_sink_bound: assert property (@(posedge clk) disable iff (!rst_n)
        held <= int'(CREDIT_DEPTH))
        else fail_now($sformatf("[FAIL] sink held=%h over depth %h",
                                $sampled(held), CREDIT_DEPTH));

    ////////////////////////////////////////////////////////////
    // sink
    ////////////////////////////////////////////////////////////
    // takes every result and returns each credit 0 to 3 cycles later with one pulse per cycle
    initial begin : sink
        logic [31:0] due_q[$];
        logic        hold_now;
        credit_i  = 1'b0;
        held      = 0;
        sink_lfsr = 16'd84;
        forever begin
            @(posedge clk);
            hold_now = withhold;
            #1;
            credit_i = 1'b0;
            if (rst_n && out_vld_o) begin
                held++;
                due_q.push_back(cyc + 32'(lfsr_bits(sink_lfsr, 2)));
            end
            if (!hold_now && due_q.size() != 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                credit_i = 1'b1;
                held--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic gen_item(input bfly_mode_e mode, output bfly_in_t x);
        x.mode = mode;
        x.a.re = 16'(lfsr_bits(lfsr_s, 16));
        x.a.im = 16'(lfsr_bits(lfsr_s, 16));
        x.b.re = 16'(lfsr_bits(lfsr_s, 16));
        x.b.im = 16'(lfsr_bits(lfsr_s, 16));
        x.w.re = 16'(lfsr_bits(lfsr_s, 16));
        x.w.im = 16'(lfsr_bits(lfsr_s, 16));
    endtask

    // in_vld_i is already high and stays high until the edge that transfers
    task automatic wait_accept();
        int tmo = 0;
        while (!in_rdy_o) begin
            @(posedge clk);
            #1;
            tmo++;
            if (tmo > TIMEOUT) begin
                fail_now("in_rdy_o stayed low, transfer timed out");
            end
        end
        @(posedge clk);
        #1;
        in_vld_i = 1'b0;
    endtask

    task automatic send_item(input bfly_in_t x);
        in_i     = x;
        in_vld_i = 1'b1;
        wait_accept();
    endtask

    // mostly back to back with a random idle cycle now and then
    task automatic run_burst(input bfly_mode_e mode, input int n);
        bfly_in_t item;
        for (int i = 0; i < n; i++) begin
            gen_item(mode, item);
            if (lfsr_bits(lfsr_s, 2) == 32'd0) begin
                @(posedge clk);
                #1;
            end
            send_item(item);
        end
    endtask

    // nothing in flight and every credit back
    task automatic wait_drain();
        int tmo = 0;
        @(posedge clk);
        while (sb_cnt != 0 || held != 0 || credit_i) begin
            tmo++;
            if (tmo > TIMEOUT) begin
                fail_now("pipeline did not drain in time");
            end
            @(posedge clk);
        end
        #1;
    endtask

    initial begin : stimulus
        bfly_in_t item;
        rst_n    = 1'b0;
        in_i     = '0;
        in_vld_i = 1'b0;
        withhold = 1'b0;
        lfsr_s   = 16'd84;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset while ready stays high
        repeat (4) begin
            @(posedge clk);
            #1;
        end

        run_burst(MODE_FFT, 48);
        run_burst(MODE_IFFT, 48);
        wait_drain();

        // back-pressure fills every credit and then keeps one more item waiting
        withhold = 1'b1;
        for (int i = 0; i < int'(CREDIT_DEPTH); i++) begin
            gen_item(MODE_FFT, item);
            send_item(item);
        end
        gen_item(MODE_IFFT, item);
        in_i     = item;
        in_vld_i = 1'b1;
        repeat (12) begin
            @(posedge clk);
            #1;
        end
        withhold = 1'b0;
        wait_accept();

        run_burst(MODE_IFFT, 16);
        run_burst(MODE_FFT, 16);
        wait_drain();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/bfly_pkg.sv
rtl/bfly_credit_ctrl.sv
rtl/bfly_preadd.sv
rtl/bfly_cmul3.sv
rtl/bfly_combine.sv
rtl/butterfly_top.sv
testbench/tb_butterfly.sv

// File: run.sh
#!/usr/bin/env bash
# build the butterfly testbench with verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f --top-module tb_butterfly -o tb_butterfly_sim \
    && ./obj_dir/tb_butterfly_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
